// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = controlUnitTb
FILELIST = src.f
BUILDDIR = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run and check the log for the pass message"
	@echo "  clean  remove build output and log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

// File: common/controlPkg.sv
package controlPkg;

  // Instruction fields and state register
  localparam int OpWidth = 6;
  localparam int FunctWidth = 6;
  localparam int StateWidth = 5;

  // Opcodes
  localparam logic [OpWidth-1:0] OpRType = 6'h00;
  localparam logic [OpWidth-1:0] OpJ = 6'h02;
  localparam logic [OpWidth-1:0] OpJal = 6'h03;
  localparam logic [OpWidth-1:0] OpBeq = 6'h04;
  localparam logic [OpWidth-1:0] OpBne = 6'h05;
  localparam logic [OpWidth-1:0] OpBle = 6'h06;
  localparam logic [OpWidth-1:0] OpBgt = 6'h07;
  localparam logic [OpWidth-1:0] OpAddi = 6'h08;
  localparam logic [OpWidth-1:0] OpAddiu = 6'h09;
  localparam logic [OpWidth-1:0] OpSlti = 6'h0A;
  localparam logic [OpWidth-1:0] OpLui = 6'h0F;
  localparam logic [OpWidth-1:0] OpLb = 6'h20;
  localparam logic [OpWidth-1:0] OpLh = 6'h21;
  localparam logic [OpWidth-1:0] OpLw = 6'h23;
  localparam logic [OpWidth-1:0] OpSb = 6'h28;
  localparam logic [OpWidth-1:0] OpSh = 6'h29;
  localparam logic [OpWidth-1:0] OpSw = 6'h2B;

  // Funct codes under OpRType
  localparam logic [FunctWidth-1:0] FnJr = 6'h08;
  localparam logic [FunctWidth-1:0] FnAdd = 6'h20;
  localparam logic [FunctWidth-1:0] FnSub = 6'h22;
  localparam logic [FunctWidth-1:0] FnAnd = 6'h24;
  localparam logic [FunctWidth-1:0] FnSlt = 6'h2A;

  // FSM states, kept contiguous from StFetch to StLui
  localparam logic [StateWidth-1:0] StFetch = 5'd0;
  localparam logic [StateWidth-1:0] StWait = 5'd1;
  localparam logic [StateWidth-1:0] StDecode = 5'd2;
  localparam logic [StateWidth-1:0] StInvalid1 = 5'd3;
  localparam logic [StateWidth-1:0] StInvalid2 = 5'd4;
  localparam logic [StateWidth-1:0] StAnd = 5'd5;
  localparam logic [StateWidth-1:0] StAdd = 5'd6;
  localparam logic [StateWidth-1:0] StAddi = 5'd7;
  localparam logic [StateWidth-1:0] StSub = 5'd8;
  localparam logic [StateWidth-1:0] StAluWb = 5'd9;
  localparam logic [StateWidth-1:0] StOverflow1 = 5'd10;
  localparam logic [StateWidth-1:0] StOverflow2 = 5'd11;
  localparam logic [StateWidth-1:0] StSlt = 5'd12;
  localparam logic [StateWidth-1:0] StSlti = 5'd13;
  localparam logic [StateWidth-1:0] StSltWb = 5'd14;
  localparam logic [StateWidth-1:0] StMemAddr = 5'd15;
  localparam logic [StateWidth-1:0] StLoad = 5'd16;
  localparam logic [StateWidth-1:0] StLoadWb = 5'd17;
  localparam logic [StateWidth-1:0] StStore = 5'd18;
  localparam logic [StateWidth-1:0] StBranch = 5'd19;
  localparam logic [StateWidth-1:0] StJal = 5'd20;
  localparam logic [StateWidth-1:0] StLinkWb = 5'd21;
  localparam logic [StateWidth-1:0] StJump = 5'd22;
  localparam logic [StateWidth-1:0] StJr = 5'd23;
  localparam logic [StateWidth-1:0] StJrPc = 5'd24;
  localparam logic [StateWidth-1:0] StLui = 5'd25;

  // ALU operations
  localparam logic [2:0] AluPass = 3'b000;
  localparam logic [2:0] AluAdd = 3'b001;
  localparam logic [2:0] AluSub = 3'b010;
  localparam logic [2:0] AluAnd = 3'b011;
  localparam logic [2:0] AluCmp = 3'b111;

  // PC source mux
  localparam logic [2:0] PcAlu = 3'b000;
  localparam logic [2:0] PcJump = 3'b001;
  localparam logic [2:0] PcVector = 3'b010;
  localparam logic [2:0] PcAluOut = 3'b011;

  // Memory address mux
  localparam logic [2:0] AddrPc = 3'b000;
  localparam logic [2:0] AddrAlu = 3'b001;
  localparam logic [2:0] AddrInvalidVec = 3'b010;
  localparam logic [2:0] AddrOverflowVec = 3'b011;

  // Register write data mux
  localparam logic [2:0] WbAlu = 3'b000;
  localparam logic [2:0] WbMem = 3'b101;
  localparam logic [2:0] WbLui = 3'b110;

  // Destination register mux, DstRa selects r31
  localparam logic [1:0] DstRt = 2'b00;
  localparam logic [1:0] DstRd = 2'b01;
  localparam logic [1:0] DstRa = 2'b11;

  // Branch conditions
  localparam logic [1:0] CondBne = 2'b00;
  localparam logic [1:0] CondBeq = 2'b01;
  localparam logic [1:0] CondBle = 2'b10;
  localparam logic [1:0] CondBgt = 2'b11;

  // Load/store access width
  localparam logic [1:0] SizeByte = 2'b01;
  localparam logic [1:0] SizeHalf = 2'b10;
  localparam logic [1:0] SizeWord = 2'b11;

endpackage

// File: controller/controlDrive.sv
module controlDrive (
  input  logic clk,
  input  logic reset_in,
  input  logic [controlPkg::StateWidth-1:0] nextState,
  input  logic [1:0] branchCond,
  input  logic [1:0] accessSize,
  output logic pcWriteCond,
  output logic pcWrite,
  output logic memRead,
  output logic memWrite,
  output logic irWrite,
  output logic regWrite,
  output logic lsStore,
  output logic ltOut,
  output logic [1:0] condControl,
  output logic [2:0] aluOp,
  output logic [1:0] lsSize,
  output logic [2:0] iorD,
  output logic [1:0] regDst,
  output logic [2:0] memToReg,
  output logic aluSrcA,
  output logic [1:0] aluSrcB,
  output logic [2:0] pcSource
);

  // Everything idles low, the entered state raises what it needs
  always_ff @(posedge clk) begin
    pcWriteCond <= 1'b0;
    pcWrite <= 1'b0;
    memRead <= 1'b0;
    memWrite <= 1'b0;
    irWrite <= 1'b0;
    regWrite <= 1'b0;
    lsStore <= 1'b0;
    ltOut <= 1'b0;
    condControl <= 2'b00;
    aluOp <= controlPkg::AluPass;
    lsSize <= 2'b00;
    iorD <= controlPkg::AddrPc;
    regDst <= controlPkg::DstRt;
    memToReg <= controlPkg::WbAlu;
    aluSrcA <= 1'b0;
    aluSrcB <= 2'b00;
    pcSource <= controlPkg::PcAlu;

    if (!reset_in) begin
      case (nextState)
        controlPkg::StFetch: begin
          memRead <= 1'b1;
          irWrite <= 1'b1;
          aluSrcB <= 2'b11;
          aluOp <= controlPkg::AluAdd;
          pcWrite <= 1'b1;
        end
        // Branch target computed ahead of execute
        controlPkg::StDecode: begin
          aluSrcB <= 2'b10;
          aluOp <= controlPkg::AluAdd;
        end
        controlPkg::StInvalid2: begin
          iorD <= controlPkg::AddrInvalidVec;
          memRead <= 1'b1;
          pcSource <= controlPkg::PcVector;
          pcWrite <= 1'b1;
        end
        controlPkg::StOverflow2: begin
          iorD <= controlPkg::AddrOverflowVec;
          memRead <= 1'b1;
          pcSource <= controlPkg::PcVector;
          pcWrite <= 1'b1;
        end
        controlPkg::StAnd: begin
          aluSrcA <= 1'b1;
          aluOp <= controlPkg::AluAnd;
        end
        controlPkg::StAdd: begin
          aluSrcA <= 1'b1;
          aluOp <= controlPkg::AluAdd;
        end
        controlPkg::StAddi,
        controlPkg::StMemAddr: begin
          aluSrcA <= 1'b1;
          aluSrcB <= 2'b01;
          aluOp <= controlPkg::AluAdd;
        end
        controlPkg::StSub: begin
          aluSrcA <= 1'b1;
          aluOp <= controlPkg::AluSub;
        end
        controlPkg::StAluWb: begin
          regDst <= controlPkg::DstRd;
          regWrite <= 1'b1;
        end
        controlPkg::StSlt: begin
          aluSrcA <= 1'b1;
          aluOp <= controlPkg::AluCmp;
        end
        controlPkg::StSlti: begin
          aluSrcA <= 1'b1;
          aluSrcB <= 2'b01;
          aluOp <= controlPkg::AluCmp;
        end
        controlPkg::StSltWb: begin
          ltOut <= 1'b1;
          regDst <= controlPkg::DstRd;
          regWrite <= 1'b1;
        end
        controlPkg::StLoad: begin
          iorD <= controlPkg::AddrAlu;
          memRead <= 1'b1;
        end
        controlPkg::StLoadWb: begin
          lsSize <= accessSize;
          memToReg <= controlPkg::WbMem;
          regWrite <= 1'b1;
        end
        controlPkg::StStore: begin
          iorD <= controlPkg::AddrAlu;
          lsStore <= 1'b1;
          lsSize <= accessSize;
          memWrite <= 1'b1;
        end
        controlPkg::StBranch: begin
          pcWriteCond <= 1'b1;
          aluSrcA <= 1'b1;
          aluOp <= controlPkg::AluCmp;
          pcSource <= controlPkg::PcAluOut;
          condControl <= branchCond;
        end
        // Return address is PC plus four
        controlPkg::StJal: begin
          aluSrcB <= 2'b11;
          aluOp <= controlPkg::AluAdd;
        end
        controlPkg::StLinkWb: begin
          regDst <= controlPkg::DstRa;
          regWrite <= 1'b1;
        end
        controlPkg::StJump: begin
          pcSource <= controlPkg::PcJump;
          pcWrite <= 1'b1;
        end
        controlPkg::StJr: aluSrcA <= 1'b1;
        controlPkg::StJrPc: begin
          pcSource <= controlPkg::PcAluOut;
          pcWrite <= 1'b1;
        end
        controlPkg::StLui: begin
          memToReg <= controlPkg::WbLui;
          regWrite <= 1'b1;
        end
        default: begin
        end
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (reset_in) !(memRead && memWrite));
  assert property (@(posedge clk) disable iff (reset_in) !(pcWrite && pcWriteCond));
  // Instruction register only loads from a live memory read
  assert property (@(posedge clk) disable iff (reset_in) irWrite |-> memRead);

endmodule

// File: controller/stateSequencer.sv
module stateSequencer (
  input  logic clk,
  input  logic reset_in,
  input  logic [controlPkg::StateWidth-1:0] dispatchState,
  input  logic isLoad,
  input  logic overflow,
  output logic [controlPkg::StateWidth-1:0] state,
  output logic [controlPkg::StateWidth-1:0] nextState
);

  // Low for the first cycle out of reset so fetch is entered with its outputs
  logic started;

  always_ff @(posedge clk) begin
    if (reset_in) begin
      state <= controlPkg::StFetch;
      started <= 1'b0;
    end else begin
      state <= nextState;
      started <= 1'b1;
    end
  end

  always_comb begin
    if (!started) begin
      nextState = controlPkg::StFetch;
    end else begin
      case (state)
        controlPkg::StFetch: nextState = controlPkg::StWait;
        controlPkg::StWait: nextState = controlPkg::StDecode;
        controlPkg::StDecode: nextState = dispatchState;

        controlPkg::StInvalid1: nextState = controlPkg::StInvalid2;
        controlPkg::StInvalid2: nextState = controlPkg::StFetch;

        controlPkg::StAnd,
        controlPkg::StAdd,
        controlPkg::StAddi,
        controlPkg::StSub: nextState = controlPkg::StAluWb;
        controlPkg::StAluWb: begin
          if (overflow) begin
            nextState = controlPkg::StOverflow1;
          end else begin
            nextState = controlPkg::StFetch;
          end
        end
        controlPkg::StOverflow1: nextState = controlPkg::StOverflow2;
        controlPkg::StOverflow2: nextState = controlPkg::StFetch;

        controlPkg::StSlt,
        controlPkg::StSlti: nextState = controlPkg::StSltWb;
        controlPkg::StSltWb: nextState = controlPkg::StFetch;

        controlPkg::StMemAddr: begin
          if (isLoad) begin
            nextState = controlPkg::StLoad;
          end else begin
            nextState = controlPkg::StStore;
          end
        end
        controlPkg::StLoad: nextState = controlPkg::StLoadWb;
        controlPkg::StLoadWb: nextState = controlPkg::StFetch;
        controlPkg::StStore: nextState = controlPkg::StFetch;

        controlPkg::StBranch: nextState = controlPkg::StFetch;

        // jal links r31 first, then takes the plain jump
        controlPkg::StJal: nextState = controlPkg::StLinkWb;
        controlPkg::StLinkWb: nextState = controlPkg::StJump;
        controlPkg::StJump: nextState = controlPkg::StFetch;
        controlPkg::StJr: nextState = controlPkg::StJrPc;
        controlPkg::StJrPc: nextState = controlPkg::StFetch;

        controlPkg::StLui: nextState = controlPkg::StFetch;
        default: nextState = controlPkg::StFetch;
      endcase
    end
  end

  // Decoder dispatch must never land outside the encoded range
  assert property (@(posedge clk) disable iff (reset_in)
    state inside {[controlPkg::StFetch:controlPkg::StLui]});

endmodule

// File: hdl/controlUnit.sv
module controlUnit (
  input  logic clk,
  input  logic reset_in,
  input  logic [controlPkg::OpWidth-1:0] opcode,
  input  logic [controlPkg::FunctWidth-1:0] funct,
  input  logic overflow,
  output logic pcWriteCond,
  output logic pcWrite,
  output logic memRead,
  output logic memWrite,
  output logic irWrite,
  output logic regWrite,
  output logic lsStore,
  output logic ltOut,
  output logic [1:0] condControl,
  output logic [2:0] aluOp,
  output logic [1:0] lsSize,
  output logic [2:0] iorD,
  output logic [1:0] regDst,
  output logic [2:0] memToReg,
  output logic aluSrcA,
  output logic [1:0] aluSrcB,
  output logic [2:0] pcSource
);

  logic [controlPkg::StateWidth-1:0] dispatchState;
  logic [1:0] branchCond;
  logic [1:0] accessSize;
  logic isLoad;
  logic [controlPkg::StateWidth-1:0] nextState;

  instrDecoder decoder0 (
    .opcode(opcode),
    .funct(funct),
    .dispatchState(dispatchState),
    .branchCond(branchCond),
    .accessSize(accessSize),
    .isLoad(isLoad)
  );

  stateSequencer sequencer0 (
    .clk(clk),
    .reset_in(reset_in),
    .dispatchState(dispatchState),
    .isLoad(isLoad),
    .overflow(overflow),
    .state(),
    .nextState(nextState)
  );

  controlDrive drive0 (
    .clk(clk),
    .reset_in(reset_in),
    .nextState(nextState),
    .branchCond(branchCond),
    .accessSize(accessSize),
    .pcWriteCond(pcWriteCond),
    .pcWrite(pcWrite),
    .memRead(memRead),
    .memWrite(memWrite),
    .irWrite(irWrite),
    .regWrite(regWrite),
    .lsStore(lsStore),
    .ltOut(ltOut),
    .condControl(condControl),
    .aluOp(aluOp),
    .lsSize(lsSize),
    .iorD(iorD),
    .regDst(regDst),
    .memToReg(memToReg),
    .aluSrcA(aluSrcA),
    .aluSrcB(aluSrcB),
    .pcSource(pcSource)
  );

endmodule

// File: hdl/instrDecoder.sv
module instrDecoder (
  input  logic [controlPkg::OpWidth-1:0] opcode,
  input  logic [controlPkg::FunctWidth-1:0] funct,
  output logic [controlPkg::StateWidth-1:0] dispatchState,
  output logic [1:0] branchCond,
  output logic [1:0] accessSize,
  output logic isLoad
);

  always_comb begin
    dispatchState = controlPkg::StInvalid1;
    branchCond = controlPkg::CondBne;
    accessSize = controlPkg::SizeWord;
    isLoad = 1'b0;

    case (opcode)
      controlPkg::OpRType: begin
        case (funct)
          controlPkg::FnAdd: dispatchState = controlPkg::StAdd;
          controlPkg::FnAnd: dispatchState = controlPkg::StAnd;
          controlPkg::FnSub: dispatchState = controlPkg::StSub;
          controlPkg::FnSlt: dispatchState = controlPkg::StSlt;
          controlPkg::FnJr: dispatchState = controlPkg::StJr;
          default: dispatchState = controlPkg::StInvalid1;
        endcase
      end
      // addiu shares the add path
      controlPkg::OpAddi,
      controlPkg::OpAddiu: dispatchState = controlPkg::StAddi;
      controlPkg::OpSlti: dispatchState = controlPkg::StSlti;
      controlPkg::OpLui: dispatchState = controlPkg::StLui;
      controlPkg::OpJ: dispatchState = controlPkg::StJump;
      controlPkg::OpJal: dispatchState = controlPkg::StJal;
      controlPkg::OpBne: begin
        dispatchState = controlPkg::StBranch;
        branchCond = controlPkg::CondBne;
      end
      controlPkg::OpBeq: begin
        dispatchState = controlPkg::StBranch;
        branchCond = controlPkg::CondBeq;
      end
      controlPkg::OpBle: begin
        dispatchState = controlPkg::StBranch;
        branchCond = controlPkg::CondBle;
      end
      controlPkg::OpBgt: begin
        dispatchState = controlPkg::StBranch;
        branchCond = controlPkg::CondBgt;
      end
      controlPkg::OpLb,
      controlPkg::OpLh,
      controlPkg::OpLw: begin
        dispatchState = controlPkg::StMemAddr;
        isLoad = 1'b1;
      end
      controlPkg::OpSb,
      controlPkg::OpSh,
      controlPkg::OpSw: dispatchState = controlPkg::StMemAddr;
      default: dispatchState = controlPkg::StInvalid1;
    endcase

    // Width from the low opcode bits of the memory group
    if (opcode == controlPkg::OpLb || opcode == controlPkg::OpSb) begin
      accessSize = controlPkg::SizeByte;
    end else if (opcode == controlPkg::OpLh || opcode == controlPkg::OpSh) begin
      accessSize = controlPkg::SizeHalf;
    end
  end

endmodule

// File: src.f
common/controlPkg.sv
hdl/instrDecoder.sv
controller/stateSequencer.sv
controller/controlDrive.sv
hdl/controlUnit.sv
verification/controlChecker.sv
verification/controlUnitTb.sv

// File: verification/controlChecker.sv
module controlChecker (
  input  logic clk,
  input  logic reset_in,
  input  logic [controlPkg::OpWidth-1:0] opcode,
  input  logic [controlPkg::FunctWidth-1:0] funct,
  input  logic overflow,
  input  logic pcWriteCond,
  input  logic pcWrite,
  input  logic memRead,
  input  logic memWrite,
  input  logic irWrite,
  input  logic regWrite,
  input  logic lsStore,
  input  logic ltOut,
  input  logic [1:0] condControl,
  input  logic [2:0] aluOp,
  input  logic [1:0] lsSize,
  input  logic [2:0] iorD,
  input  logic [1:0] regDst,
  input  logic [2:0] memToReg,
  input  logic aluSrcA,
  input  logic [1:0] aluSrcB,
  input  logic [2:0] pcSource,
  output int errorCount,
  output int instrCount
);

  localparam int ClsAlu = 0;
  localparam int ClsSlt = 1;
  localparam int ClsLoad = 2;
  localparam int ClsStore = 3;
  localparam int ClsBranch = 4;
  localparam int ClsJ = 5;
  localparam int ClsJal = 6;
  localparam int ClsJr = 7;
  localparam int ClsLui = 8;
  localparam int ClsInvalid = 9;

  logic valid = 1'b0;
  logic [controlPkg::StateWidth-1:0] shown = controlPkg::StFetch;
  logic [28:0] expected = '0;
  logic [28:0] got;
  logic haveStart = 1'b0;
  logic ovfTaken = 1'b0;
  int cycles = 0;
  int curClass = ClsInvalid;
  logic [controlPkg::OpWidth-1:0] curOp = '0;
  logic [controlPkg::FunctWidth-1:0] curFn = '0;

  assign got = {pcWriteCond, pcWrite, memRead, memWrite, irWrite, regWrite, lsStore, ltOut,
                condControl, aluOp, lsSize, iorD, regDst, memToReg, aluSrcA, aluSrcB, pcSource};

  function automatic int classOf(input logic [5:0] op, input logic [5:0] fn);
    int cls;
    cls = ClsInvalid;
    case (op)
      controlPkg::OpRType: begin
        if (fn == controlPkg::FnAdd || fn == controlPkg::FnAnd || fn == controlPkg::FnSub) begin
          cls = ClsAlu;
        end else if (fn == controlPkg::FnSlt) begin
          cls = ClsSlt;
        end else if (fn == controlPkg::FnJr) begin
          cls = ClsJr;
        end
      end
      controlPkg::OpAddi, controlPkg::OpAddiu: cls = ClsAlu;
      controlPkg::OpSlti: cls = ClsSlt;
      controlPkg::OpLb, controlPkg::OpLh, controlPkg::OpLw: cls = ClsLoad;
      controlPkg::OpSb, controlPkg::OpSh, controlPkg::OpSw: cls = ClsStore;
      controlPkg::OpBeq, controlPkg::OpBne, controlPkg::OpBle, controlPkg::OpBgt: cls = ClsBranch;
      controlPkg::OpJ: cls = ClsJ;
      controlPkg::OpJal: cls = ClsJal;
      controlPkg::OpLui: cls = ClsLui;
      default: cls = ClsInvalid;
    endcase
    return cls;
  endfunction

  // Cycle budget per class, fetch to next fetch
  function automatic int cyclesOf(input int cls, input logic ovf);
    case (cls)
      ClsAlu: return ovf ? 7 : 5;
      ClsLoad: return 6;
      ClsBranch, ClsJ, ClsLui: return 4;
      ClsJal: return 6;
      default: return 5;
    endcase
  endfunction

  function automatic logic [4:0] nextOf(input logic [4:0] s, input logic [5:0] op,
                                        input logic [5:0] fn, input logic ovf);
    logic [4:0] n;
    n = controlPkg::StFetch;
    case (s)
      controlPkg::StFetch: n = controlPkg::StWait;
      controlPkg::StWait: n = controlPkg::StDecode;
      controlPkg::StDecode: begin
        case (classOf(op, fn))
          ClsAlu: begin
            if (op != controlPkg::OpRType) n = controlPkg::StAddi;
            else if (fn == controlPkg::FnAdd) n = controlPkg::StAdd;
            else if (fn == controlPkg::FnAnd) n = controlPkg::StAnd;
            else n = controlPkg::StSub;
          end
          ClsSlt: n = (op == controlPkg::OpSlti) ? controlPkg::StSlti : controlPkg::StSlt;
          ClsLoad, ClsStore: n = controlPkg::StMemAddr;
          ClsBranch: n = controlPkg::StBranch;
          ClsJ: n = controlPkg::StJump;
          ClsJal: n = controlPkg::StJal;
          ClsJr: n = controlPkg::StJr;
          ClsLui: n = controlPkg::StLui;
          default: n = controlPkg::StInvalid1;
        endcase
      end
      controlPkg::StInvalid1: n = controlPkg::StInvalid2;
      controlPkg::StAnd, controlPkg::StAdd, controlPkg::StAddi, controlPkg::StSub:
        n = controlPkg::StAluWb;
      controlPkg::StAluWb: n = ovf ? controlPkg::StOverflow1 : controlPkg::StFetch;
      controlPkg::StOverflow1: n = controlPkg::StOverflow2;
      controlPkg::StSlt, controlPkg::StSlti: n = controlPkg::StSltWb;
      controlPkg::StMemAddr:
        n = (classOf(op, fn) == ClsLoad) ? controlPkg::StLoad : controlPkg::StStore;
      controlPkg::StLoad: n = controlPkg::StLoadWb;
      controlPkg::StJal: n = controlPkg::StLinkWb;
      controlPkg::StLinkWb: n = controlPkg::StJump;
      controlPkg::StJr: n = controlPkg::StJrPc;
      default: n = controlPkg::StFetch;
    endcase
    return n;
  endfunction

  // Output word in the same bit order as got
  function automatic logic [28:0] expectOf(input logic [4:0] s, input logic [5:0] op);
    logic pwc, pw, mr, mw, ir, rw, lss, lt, srcA;
    logic [1:0] cond, size, dst, srcB;
    logic [2:0] alu, addr, wb, pc;
    {pwc, pw, mr, mw, ir, rw, lss, lt, srcA} = '0;
    {cond, size, dst, srcB, alu, addr, wb, pc} = '0;
    case (op)
      controlPkg::OpBeq: cond = controlPkg::CondBeq;
      controlPkg::OpBle: cond = controlPkg::CondBle;
      controlPkg::OpBgt: cond = controlPkg::CondBgt;
      default: cond = controlPkg::CondBne;
    endcase
    if (op == controlPkg::OpLb || op == controlPkg::OpSb) size = controlPkg::SizeByte;
    else if (op == controlPkg::OpLh || op == controlPkg::OpSh) size = controlPkg::SizeHalf;
    else size = controlPkg::SizeWord;
    if (s != controlPkg::StBranch) cond = 2'b00;
    if (s != controlPkg::StLoadWb && s != controlPkg::StStore) size = 2'b00;
    case (s)
      controlPkg::StFetch: {mr, ir, pw, srcB, alu} = {3'b111, 2'b11, controlPkg::AluAdd};
      controlPkg::StDecode: {srcB, alu} = {2'b10, controlPkg::AluAdd};
      controlPkg::StInvalid2, controlPkg::StOverflow2: begin
        addr = (s == controlPkg::StInvalid2) ? controlPkg::AddrInvalidVec
                                             : controlPkg::AddrOverflowVec;
        {mr, pw, pc} = {2'b11, controlPkg::PcVector};
      end
      controlPkg::StAnd: {srcA, alu} = {1'b1, controlPkg::AluAnd};
      controlPkg::StAdd: {srcA, alu} = {1'b1, controlPkg::AluAdd};
      controlPkg::StSub: {srcA, alu} = {1'b1, controlPkg::AluSub};
      controlPkg::StAddi, controlPkg::StMemAddr:
        {srcA, srcB, alu} = {1'b1, 2'b01, controlPkg::AluAdd};
      controlPkg::StAluWb: {dst, rw} = {controlPkg::DstRd, 1'b1};
      controlPkg::StSlt: {srcA, alu} = {1'b1, controlPkg::AluCmp};
      controlPkg::StSlti: {srcA, srcB, alu} = {1'b1, 2'b01, controlPkg::AluCmp};
      controlPkg::StSltWb: {lt, dst, rw} = {1'b1, controlPkg::DstRd, 1'b1};
      controlPkg::StLoad: {addr, mr} = {controlPkg::AddrAlu, 1'b1};
      controlPkg::StLoadWb: {wb, rw} = {controlPkg::WbMem, 1'b1};
      controlPkg::StStore: {addr, lss, mw} = {controlPkg::AddrAlu, 2'b11};
      controlPkg::StBranch:
        {pwc, srcA, alu, pc} = {2'b11, controlPkg::AluCmp, controlPkg::PcAluOut};
      controlPkg::StJal: {srcB, alu} = {2'b11, controlPkg::AluAdd};
      controlPkg::StLinkWb: {dst, rw} = {controlPkg::DstRa, 1'b1};
      controlPkg::StJump: {pc, pw} = {controlPkg::PcJump, 1'b1};
      controlPkg::StJr: srcA = 1'b1;
      controlPkg::StJrPc: {pc, pw} = {controlPkg::PcAluOut, 1'b1};
      controlPkg::StLui: {wb, rw} = {controlPkg::WbLui, 1'b1};
      default: begin
      end
    endcase
    return {pwc, pw, mr, mw, ir, rw, lss, lt, cond, alu, size, addr, dst, wb, srcA, srcB, pc};
  endfunction

  initial begin
    errorCount = 0;
    instrCount = 0;
  end

  // Model steps on the edge, from inputs only
  always @(posedge clk) begin
    if (reset_in) begin
      valid = 1'b0;
      shown = controlPkg::StFetch;
    end else if (!valid) begin
      valid = 1'b1;
      shown = controlPkg::StFetch;
    end else begin
      if (shown == controlPkg::StDecode) begin
        curClass = classOf(opcode, funct);
        curOp = opcode;
        curFn = funct;
        ovfTaken = 1'b0;
      end
      if (shown == controlPkg::StAluWb) ovfTaken = overflow;
      shown = nextOf(shown, opcode, funct, overflow);
    end
    expected = valid ? expectOf(shown, opcode) : '0;
  end

  // Outputs are settled mid-cycle
  always @(negedge clk) begin
    if (got !== expected) begin
      errorCount = errorCount + 1;
      $display("ERR %0t: outputs %h, expected %h in state %0d", $time, got, expected, shown);
    end
    if (irWrite === 1'b1) begin
      if (haveStart) begin
        if (cycles != cyclesOf(curClass, ovfTaken)) begin
          errorCount = errorCount + 1;
          $display("ERR %0t: op %h fn %h took %0d cycles, expected %0d", $time, curOp, curFn,
                   cycles, cyclesOf(curClass, ovfTaken));
        end
        instrCount = instrCount + 1;
      end
      haveStart = 1'b1;
      cycles = 1;
    end else if (haveStart) begin
      cycles = cycles + 1;
    end
  end

endmodule

// File: verification/controlUnitTb.sv
module controlUnitTb;

  localparam int NumInstr = 300;
  localparam int Period = 4;
  localparam int ResetCycles = 16;
  localparam int KeptCount = 21;
  // Worst case of seven cycles per instruction
  localparam int Timeout = NumInstr * 7 * Period + ResetCycles * Period + 400;

  logic clk = 1'b0;
  logic reset_in = 1'b1;
  logic [controlPkg::OpWidth-1:0] opcode = '0;
  logic [controlPkg::FunctWidth-1:0] funct = '0;
  logic overflow = 1'b0;
  logic pcWriteCond, pcWrite, memRead, memWrite, irWrite, regWrite, lsStore, ltOut;
  logic [1:0] condControl, lsSize, regDst, aluSrcB;
  logic [2:0] aluOp, iorD, memToReg, pcSource;
  logic aluSrcA;
  int errorCount;
  int instrCount;

  integer seed = 29;
  logic loadNext = 1'b0;
  logic [11:0] keptList [KeptCount];

  controlUnit dut0 (.*);

  controlChecker checker0 (.*);

  always #(Period / 2) clk = ~clk;

  task automatic pickInstruction();
    logic [31:0] rnd;
    logic [11:0] entry;
    rnd = $random(seed);
    if (rnd % 100 < 80) begin
      entry = keptList[rnd[31:8] % KeptCount];
      opcode = entry[11:6];
      // Funct field is immediate bits outside R-type
      funct = (entry[11:6] == controlPkg::OpRType) ? entry[5:0] : rnd[5:0];
    end else if (rnd[7]) begin
      opcode = {2'b11, rnd[3:0]};
      funct = rnd[13:8];
    end else begin
      opcode = controlPkg::OpRType;
      funct = {2'b11, rnd[3:0]};
    end
  endtask

  // Next instruction goes in after a fetch cycle
  always @(negedge clk) loadNext = irWrite;

  always @(posedge clk) begin
    logic [31:0] rnd;
    #1;
    rnd = $random(seed);
    overflow = rnd[0];
    if (loadNext) pickInstruction();
  end

  initial begin
    keptList = '{
      {controlPkg::OpRType, controlPkg::FnAdd}, {controlPkg::OpRType, controlPkg::FnAnd},
      {controlPkg::OpRType, controlPkg::FnSub}, {controlPkg::OpRType, controlPkg::FnSlt},
      {controlPkg::OpRType, controlPkg::FnJr}, {controlPkg::OpAddi, 6'h00},
      {controlPkg::OpAddiu, 6'h00}, {controlPkg::OpSlti, 6'h00}, {controlPkg::OpLui, 6'h00},
      {controlPkg::OpLb, 6'h00}, {controlPkg::OpLh, 6'h00}, {controlPkg::OpLw, 6'h00},
      {controlPkg::OpSb, 6'h00}, {controlPkg::OpSh, 6'h00}, {controlPkg::OpSw, 6'h00},
      {controlPkg::OpBeq, 6'h00}, {controlPkg::OpBne, 6'h00}, {controlPkg::OpBle, 6'h00},
      {controlPkg::OpBgt, 6'h00}, {controlPkg::OpJ, 6'h00}, {controlPkg::OpJal, 6'h00}
    };
    pickInstruction();
    repeat (ResetCycles) @(posedge clk);
    #1;
    reset_in = 1'b0;
    wait (instrCount >= NumInstr);
    @(posedge clk);
    $display("Errors: %0d, instructions checked: %0d", errorCount, instrCount);
    if (errorCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    #(Timeout);
    $display("Watchdog timeout: only %0d of %0d instructions completed", instrCount, NumInstr);
    $display("Testbench failed");
    $finish;
  end

endmodule
